/* logic/axil_wb_pkg.sv */
////////////////////////////////////////////////////////////
// AXI-lite to Wishbone write bridge
// Shared widths and types
////////////////////////////////////////////////////////////

`default_nettype none

package axil_wb_pkg;

	// Bus widths
	localparam int AXI_ADDR_W = 28;
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;

	// Byte offset bits dropped on the way to Wishbone
	localparam int ADDR_LSBS = 2;
	localparam int WB_ADDR_W = AXI_ADDR_W - ADDR_LSBS;

	// Response queue, 8 writes in flight
	localparam int LGFIFO = 3;
	localparam int FIFO_DEPTH = 1 << LGFIFO;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;

	// Queue pointer, extra top bit tells full from empty
	typedef logic [LGFIFO:0] ptr_t;

	// B channel response codes
	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// One joined write, address already in words
	typedef struct packed
	{
		wb_addr_t addr;
		data_t data;
		sel_t sel;
	} wr_req_t;

endpackage

`default_nettype wire

/* logic/axil_write_join.sv */
////////////////////////////////////////////////////////////
// AXI-lite AW/W join
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module axil_write_join
	import axil_wb_pkg::*;
(
	input wire i_clk,
	input wire w_reset,
	// Write address channel
	input wire i_axi_awvalid,
	output logic o_axi_awready,
	input wire axi_addr_t i_axi_awaddr,
	// Write data channel
	input wire i_axi_wvalid,
	output logic o_axi_wready,
	input wire data_t i_axi_wdata,
	input wire sel_t i_axi_wstrb,
	// Joined request toward the Wishbone master
	output wr_req_t o_req,
	output logic o_req_valid,
	input wire i_req_ready
);

	// Slot flags
	logic r_aw_full;
	logic r_w_full;

	// Slot contents
	wb_addr_t r_addr;
	data_t r_data;
	sel_t r_sel;

	// Handshakes
	logic w_aw_take;
	logic w_w_take;
	logic w_req_take;

	assign w_aw_take = i_axi_awvalid && o_axi_awready;
	assign w_w_take = i_axi_wvalid && o_axi_wready;
	assign w_req_take = o_req_valid && i_req_ready;

	////////////////////////////////////////////////////////////
	// Holding slots
	////////////////////////////////////////////////////////////

	// Address slot fills on AW, empties when the joined write leaves
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_aw_full <= 1'b0;
		else if (w_aw_take)
			r_aw_full <= 1'b1;
		else if (w_req_take)
			r_aw_full <= 1'b0;
	end

	// Data slot, same rule on W
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_w_full <= 1'b0;
		else if (w_w_take)
			r_w_full <= 1'b1;
		else if (w_req_take)
			r_w_full <= 1'b0;
	end

	// Word address only, byte offset goes away here
	always_ff @(posedge i_clk)
	begin
		if (w_aw_take)
			r_addr <= i_axi_awaddr[AXI_ADDR_W-1:ADDR_LSBS];
	end

	always_ff @(posedge i_clk)
	begin
		if (w_w_take)
		begin
			r_data <= i_axi_wdata;
			r_sel <= i_axi_wstrb;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Ready while the slot is empty, so a stalled bridge stops both channels
	assign o_axi_awready = !r_aw_full;
	assign o_axi_wready = !r_w_full;

	// Request once both halves are held
	assign o_req_valid = r_aw_full && r_w_full;
	assign o_req = '{addr: r_addr, data: r_data, sel: r_sel};

	// Held request must not change before the master takes it
	a_req_stable: assert property (@(posedge i_clk) disable iff (w_reset)
		o_req_valid && !i_req_ready |=> o_req_valid && $stable(o_req));

endmodule

`default_nettype wire

/* logic/wb_write_master.sv */
////////////////////////////////////////////////////////////
// Pipelined Wishbone write master
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module wb_write_master
	import axil_wb_pkg::*;
(
	input wire i_clk,
	input wire w_reset,
	// Joined request from the AW/W join
	input wire wr_req_t i_req,
	input wire i_req_valid,
	output logic o_req_ready,
	// Queue room from the response tracker
	input wire i_can_accept,
	output logic o_issue,
	// Completion pulses for the tracker
	output logic o_done_ack,
	output logic o_done_err,
	// Wishbone master side
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output wb_addr_t o_wb_addr,
	output data_t o_wb_data,
	output sel_t o_wb_sel,
	input wire i_wb_ack,
	input wire i_wb_stall,
	input wire i_wb_err
);

	// Strobes taken by the slave but not yet acknowledged
	ptr_t r_outstanding;

	// Strobe register can take a new write this cycle
	logic w_slot_free;
	// Slave accepts the current strobe
	logic w_accept;

	assign w_slot_free = !o_wb_stb || !i_wb_stall;
	assign w_accept = o_wb_stb && !i_wb_stall;

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	// Need a free strobe and a free queue entry
	assign o_req_ready = w_slot_free && i_can_accept;
	assign o_issue = i_req_valid && o_req_ready;

	// Bus answers only count inside a cycle
	assign o_done_ack = o_wb_cyc && i_wb_ack;
	assign o_done_err = o_wb_cyc && i_wb_err;

	////////////////////////////////////////////////////////////
	// Strobe and payload
	////////////////////////////////////////////////////////////

	// Err aborts the cycle, any pending strobe is dropped
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_wb_stb <= 1'b0;
		else if (o_done_err)
			o_wb_stb <= 1'b0;
		else if (o_issue)
			o_wb_stb <= 1'b1;
		else if (!i_wb_stall)
			o_wb_stb <= 1'b0;
	end

	// Only loaded when the strobe is free, so held through stall
	always_ff @(posedge i_clk)
	begin
		if (o_issue)
		begin
			o_wb_addr <= i_req.addr;
			o_wb_data <= i_req.data;
			o_wb_sel <= i_req.sel;
		end
	end

	////////////////////////////////////////////////////////////
	// Outstanding acknowledgments
	////////////////////////////////////////////////////////////

	// Up on accept, down on ack, both together leave it alone
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_outstanding <= '0;
		else if (o_done_err)
			r_outstanding <= '0;
		else
		begin
			case ({w_accept, o_done_ack})
			2'b10:
				r_outstanding <= r_outstanding + 1'b1;
			2'b01:
				r_outstanding <= r_outstanding - 1'b1;
			default:
				r_outstanding <= r_outstanding;
			endcase
		end
	end

	// Cycle held while a strobe waits or an ack is due
	assign o_wb_cyc = o_wb_stb || (r_outstanding != '0);

	// Tracker must keep the bus within the queue depth
	a_outstanding_bound: assert property (@(posedge i_clk) disable iff (w_reset)
		r_outstanding <= ptr_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* logic/write_resp_tracker.sv */
////////////////////////////////////////////////////////////
// Write response queue and B channel
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module write_resp_tracker
	import axil_wb_pkg::*;
(
	input wire i_clk,
	input wire w_reset,
	// Events from the Wishbone master
	input wire i_issue,
	input wire i_done_ack,
	input wire i_done_err,
	// Flow control back to the master
	output logic o_can_accept,
	// AXI write response channel
	output logic o_axi_bvalid,
	input wire i_axi_bready,
	output resp_t o_axi_bresp
);

	// Issued, completed and answered write counts
	ptr_t r_first;
	ptr_t r_mid;
	ptr_t r_last;

	// Position of the erroring write
	ptr_t r_err_loc;
	logic r_err_state;

	// Derived queue state
	ptr_t w_fill;
	ptr_t w_next_last;
	ptr_t w_err_seen;
	ptr_t w_err_span;
	logic w_full;
	logic w_b_take;

	assign w_fill = r_first - r_last;
	assign w_full = (w_fill == ptr_t'(FIFO_DEPTH));
	assign w_next_last = r_last + 1'b1;
	assign w_b_take = o_axi_bvalid && i_axi_bready;

	// No new writes while full or while the error drains
	assign o_can_accept = !w_full && !r_err_state;

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_first <= '0;
		else if (i_issue)
			r_first <= r_first + 1'b1;
	end

	// In error state walk over the abandoned writes one per cycle
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_mid <= '0;
		else if (i_done_ack || i_done_err)
			r_mid <= r_mid + 1'b1;
		else if (r_err_state && (r_mid != r_first))
			r_mid <= r_mid + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_last <= '0;
		else if (w_b_take)
			r_last <= w_next_last;
	end

	////////////////////////////////////////////////////////////
	// Error state
	////////////////////////////////////////////////////////////

	// The erroring write sits at the current middle pointer
	always_ff @(posedge i_clk)
	begin
		if (i_done_err)
			r_err_loc <= r_mid;
	end

	// Left once every issued write got its B beat
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_err_state <= 1'b0;
		else if (i_done_err)
			r_err_state <= 1'b1;
		else if (r_first == r_last)
			r_err_state <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// B channel
	////////////////////////////////////////////////////////////

	// Normally answers up to mid, in error state up to first
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_axi_bvalid <= 1'b0;
		else if (i_done_ack || i_done_err)
			o_axi_bvalid <= 1'b1;
		else if (w_b_take)
		begin
			if (r_err_state)
				o_axi_bvalid <= (w_next_last != r_first);
			else
				o_axi_bvalid <= (w_next_last != r_mid);
		end
	end

	// Distances from the error position, modulo the pointer width
	assign w_err_seen = r_last - r_err_loc;
	assign w_err_span = r_first - r_err_loc;

	// Writes before the error still get OKAY
	assign o_axi_bresp = (r_err_state && (w_err_seen < w_err_span)) ?
		RESP_SLVERR : RESP_OKAY;

	// Never more writes in flight than the queue can answer
	a_fill_bound: assert property (@(posedge i_clk) disable iff (w_reset)
		w_fill <= ptr_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* logic/axil_wb_write_bridge.sv */
////////////////////////////////////////////////////////////
// AXI-lite write to Wishbone bridge
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module axil_wb_write_bridge
	import axil_wb_pkg::*;
(
	input wire i_clk,
	input wire w_reset,
	// AXI-lite write slave
	input wire i_axi_awvalid,
	output wire o_axi_awready,
	input wire axi_addr_t i_axi_awaddr,
	input wire i_axi_wvalid,
	output wire o_axi_wready,
	input wire data_t i_axi_wdata,
	input wire sel_t i_axi_wstrb,
	output wire o_axi_bvalid,
	input wire i_axi_bready,
	output wire resp_t o_axi_bresp,
	// Pipelined Wishbone master
	output wire o_wb_cyc,
	output wire o_wb_stb,
	output wire wb_addr_t o_wb_addr,
	output wire data_t o_wb_data,
	output wire sel_t o_wb_sel,
	input wire i_wb_ack,
	input wire i_wb_stall,
	input wire i_wb_err
);

	// Join to master
	wr_req_t w_req;
	logic w_req_valid;
	logic w_req_ready;

	// Master and tracker
	logic w_can_accept;
	logic w_issue;
	logic w_done_ack;
	logic w_done_err;

	axil_write_join u_join (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_axi_awvalid(i_axi_awvalid),
		.o_axi_awready(o_axi_awready),
		.i_axi_awaddr(i_axi_awaddr),
		.i_axi_wvalid(i_axi_wvalid),
		.o_axi_wready(o_axi_wready),
		.i_axi_wdata(i_axi_wdata),
		.i_axi_wstrb(i_axi_wstrb),
		.o_req(w_req),
		.o_req_valid(w_req_valid),
		.i_req_ready(w_req_ready)
	);

	wb_write_master u_master (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_req(w_req),
		.i_req_valid(w_req_valid),
		.o_req_ready(w_req_ready),
		.i_can_accept(w_can_accept),
		.o_issue(w_issue),
		.o_done_ack(w_done_ack),
		.o_done_err(w_done_err),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data),
		.o_wb_sel(o_wb_sel),
		.i_wb_ack(i_wb_ack),
		.i_wb_stall(i_wb_stall),
		.i_wb_err(i_wb_err)
	);

	// Sees only issue and completion pulses, never the bus
	write_resp_tracker u_tracker (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_issue(w_issue),
		.i_done_ack(w_done_ack),
		.i_done_err(w_done_err),
		.o_can_accept(w_can_accept),
		.o_axi_bvalid(o_axi_bvalid),
		.i_axi_bready(i_axi_bready),
		.o_axi_bresp(o_axi_bresp)
	);

endmodule

`default_nettype wire

/* sim/wb_slave_model.sv */
////////////////////////////////////////////////////////////
// Wishbone slave model
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module wb_slave_model
	import axil_wb_pkg::*;
(
	input wire i_clk,
	input wire w_reset,
	// Wishbone slave side
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire wb_addr_t i_wb_addr,
	input wire data_t i_wb_data,
	input wire sel_t i_wb_sel,
	output logic o_wb_ack,
	output logic o_wb_stall,
	output logic o_wb_err,
	// Stall pattern from the testbench
	input wire i_stall_req,
	// Last accepted write, valid with its ack or err
	output logic o_log_valid,
	output wb_addr_t o_log_addr,
	output data_t o_log_data,
	output sel_t o_log_sel,
	output int o_log_count
);

	logic w_accept;

	assign o_wb_stall = i_stall_req;
	assign w_accept = i_wb_cyc && i_wb_stb && !o_wb_stall;

	// Answer one cycle after accept, top address bit selects err
	always @(posedge i_clk)
	begin
		if (w_reset)
		begin
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
			o_log_valid <= 1'b0;
			o_log_count <= 0;
		end
		else
		begin
			o_wb_ack <= w_accept && !i_wb_addr[WB_ADDR_W-1];
			o_wb_err <= w_accept && i_wb_addr[WB_ADDR_W-1];
			o_log_valid <= w_accept;
			if (w_accept)
			begin
				o_log_addr <= i_wb_addr;
				o_log_data <= i_wb_data;
				o_log_sel <= i_wb_sel;
				o_log_count <= o_log_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_axil_wb_write_bridge.sv */
////////////////////////////////////////////////////////////
// AXI-lite to Wishbone bridge testbench
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module tb_axil_wb_write_bridge
	import axil_wb_pkg::*;
;

	localparam int WAIT_LIMIT = 500;

	logic i_clk;
	logic w_reset;
	logic i_axi_awvalid;
	axi_addr_t i_axi_awaddr;
	logic i_axi_wvalid;
	data_t i_axi_wdata;
	sel_t i_axi_wstrb;
	logic i_axi_bready;
	logic stall_req;
	wire o_axi_awready;
	wire o_axi_wready;
	wire o_axi_bvalid;
	wire resp_t o_axi_bresp;
	wire wb_cyc;
	wire wb_stb;
	wire wb_addr_t wb_addr;
	wire data_t wb_data;
	wire sel_t wb_sel;
	wire wb_ack;
	wire wb_stall;
	wire wb_err;
	wire log_valid;
	wire wb_addr_t log_addr;
	wire data_t log_data;
	wire sel_t log_sel;
	int log_count;

	// Reference queues of sent writes and expected responses
	wr_req_t wb_q[$];
	resp_t resp_q[$];
	wb_addr_t exp_addr;
	data_t exp_data;
	sel_t exp_sel;
	resp_t exp_resp;
	int wb_pending;
	int resp_pending;
	int aw_count;
	int b_count;
	int sent_count;

	// Random bus behavior
	int unsigned stim_seed;
	int unsigned bus_seed;
	logic stall_rand;
	logic bready_rand;
	int bready_hold;

	axil_wb_write_bridge dut (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_axi_awvalid(i_axi_awvalid),
		.o_axi_awready(o_axi_awready),
		.i_axi_awaddr(i_axi_awaddr),
		.i_axi_wvalid(i_axi_wvalid),
		.o_axi_wready(o_axi_wready),
		.i_axi_wdata(i_axi_wdata),
		.i_axi_wstrb(i_axi_wstrb),
		.o_axi_bvalid(o_axi_bvalid),
		.i_axi_bready(i_axi_bready),
		.o_axi_bresp(o_axi_bresp),
		.o_wb_cyc(wb_cyc),
		.o_wb_stb(wb_stb),
		.o_wb_addr(wb_addr),
		.o_wb_data(wb_data),
		.o_wb_sel(wb_sel),
		.i_wb_ack(wb_ack),
		.i_wb_stall(wb_stall),
		.i_wb_err(wb_err)
	);

	wb_slave_model u_slave (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_wb_cyc(wb_cyc),
		.i_wb_stb(wb_stb),
		.i_wb_addr(wb_addr),
		.i_wb_data(wb_data),
		.i_wb_sel(wb_sel),
		.o_wb_ack(wb_ack),
		.o_wb_stall(wb_stall),
		.o_wb_err(wb_err),
		.i_stall_req(stall_req),
		.o_log_valid(log_valid),
		.o_log_addr(log_addr),
		.o_log_data(log_data),
		.o_log_sel(log_sel),
		.o_log_count(log_count)
	);

	// 4 ns clock
	initial
	begin
		i_clk = 1'b0;
		forever
			#2 i_clk = ~i_clk;
	end

	function automatic int unsigned lcg_step(input int unsigned state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		abort_run();
	endtask

	////////////////////////////////////////////////////////////
	// Reference model bookkeeping
	////////////////////////////////////////////////////////////

	// Pops on the edge where a write or B beat is seen
	always @(posedge i_clk)
	begin
		if (w_reset)
		begin
			aw_count <= 0;
			b_count <= 0;
		end
		else
		begin
			if (log_valid && wb_q.size() != 0)
				void'(wb_q.pop_front());
			if (o_axi_bvalid && i_axi_bready)
			begin
				b_count <= b_count + 1;
				if (resp_q.size() != 0)
					void'(resp_q.pop_front());
			end
			if (i_axi_awvalid && o_axi_awready)
				aw_count <= aw_count + 1;
		end
	end

	// Queue heads for the next posedge
	always @(negedge i_clk)
	begin
		wb_pending = wb_q.size();
		resp_pending = resp_q.size();
		if (wb_q.size() != 0)
		begin
			exp_addr = wb_q[0].addr;
			exp_data = wb_q[0].data;
			exp_sel = wb_q[0].sel;
		end
		if (resp_q.size() != 0)
			exp_resp = resp_q[0];
	end

	// Random stall and bready, with an optional hold of bready low
	always @(negedge i_clk)
	begin
		bus_seed = lcg_step(bus_seed);
		stall_req = stall_rand && (bus_seed[13:12] == 2'b00);
		bus_seed = lcg_step(bus_seed);
		if (bready_hold != 0)
		begin
			i_axi_bready = 1'b0;
			bready_hold = bready_hold - 1;
		end
		else
			i_axi_bready = !bready_rand || (bus_seed[15:14] != 2'b00);
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_wb_expected: assert property (@(posedge i_clk) disable iff (w_reset)
		log_valid |-> wb_pending != 0)
		else report_mismatch("wb_pending", $sampled(wb_pending), 1);
	a_wb_addr: assert property (@(posedge i_clk) disable iff (w_reset)
		log_valid |-> log_addr == exp_addr)
		else report_mismatch("o_wb_addr", $sampled(log_addr), $sampled(exp_addr));
	a_wb_data: assert property (@(posedge i_clk) disable iff (w_reset)
		log_valid |-> log_data == exp_data)
		else report_mismatch("o_wb_data", $sampled(log_data), $sampled(exp_data));
	a_wb_sel: assert property (@(posedge i_clk) disable iff (w_reset)
		log_valid |-> log_sel == exp_sel)
		else report_mismatch("o_wb_sel", $sampled(log_sel), $sampled(exp_sel));
	a_b_expected: assert property (@(posedge i_clk) disable iff (w_reset)
		o_axi_bvalid && i_axi_bready |-> resp_pending != 0)
		else report_mismatch("resp_pending", $sampled(resp_pending), 1);
	a_bresp: assert property (@(posedge i_clk) disable iff (w_reset)
		o_axi_bvalid && i_axi_bready |-> o_axi_bresp == exp_resp)
		else report_mismatch("o_axi_bresp", $sampled(o_axi_bresp), $sampled(exp_resp));
	// Writes on the bus but not yet answered
	a_in_flight: assert property (@(posedge i_clk) disable iff (w_reset)
		log_count - b_count <= FIFO_DEPTH)
		else report_mismatch("in flight", $sampled(log_count - b_count), FIFO_DEPTH);
	// Queue full plus a held write means AW must stall
	a_full_blocks_aw: assert property (@(posedge i_clk) disable iff (w_reset)
		aw_count - b_count > FIFO_DEPTH |-> !o_axi_awready)
		else report_mismatch("o_axi_awready", $sampled(o_axi_awready), 0);

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Order 0 sends both, 1 sends AW first, 2 sends W first
	task automatic send_write(input axi_addr_t addr, input data_t data, input sel_t sel,
		input int order, input int gap);
		int cycles;
		logic aw_done;
		logic w_done;
		wr_req_t req;
		cycles = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		req.addr = addr[AXI_ADDR_W-1:2];
		req.data = data;
		req.sel = sel;
		wb_q.push_back(req);
		resp_q.push_back(addr[AXI_ADDR_W-1] ? RESP_SLVERR : RESP_OKAY);
		sent_count = sent_count + 1;
		i_axi_awaddr = addr;
		i_axi_wdata = data;
		i_axi_wstrb = sel;
		i_axi_awvalid = (order != 2);
		i_axi_wvalid = (order != 1);
		while (!(aw_done && w_done))
		begin
			@(posedge i_clk);
			if (i_axi_awvalid && o_axi_awready)
				aw_done = 1'b1;
			if (i_axi_wvalid && o_axi_wready)
				w_done = 1'b1;
			@(negedge i_clk);
			cycles++;
			i_axi_awvalid = !aw_done && (order != 2 || cycles >= gap);
			i_axi_wvalid = !w_done && (order != 1 || cycles >= gap);
			if (cycles > WAIT_LIMIT)
				timeout_fail("AW and W handshakes");
		end
	endtask

	task automatic wait_all_responses();
		int cycles;
		cycles = 0;
		while (resp_q.size() != 0)
		begin
			@(negedge i_clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				timeout_fail("outstanding B responses");
		end
	endtask

	initial
	begin
		int i;
		int unsigned s1;
		int unsigned s2;
		w_reset = 1'b1;
		i_axi_awvalid = 1'b0;
		i_axi_awaddr = '0;
		i_axi_wvalid = 1'b0;
		i_axi_wdata = '0;
		i_axi_wstrb = '0;
		i_axi_bready = 1'b0;
		stall_req = 1'b0;
		stall_rand = 1'b0;
		bready_rand = 1'b0;
		bready_hold = 0;
		sent_count = 0;
		stim_seed = 7;
		bus_seed = 7;
		repeat (2)
			@(negedge i_clk);
		w_reset = 1'b0;
		@(negedge i_clk);

		// Channel order cases, quiet bus
		send_write(28'h000_1004, 32'h1111_2222, 4'hf, 1, 2);
		send_write(28'h000_2009, 32'h3333_4444, 4'h3, 2, 2);
		send_write(28'h000_300e, 32'h5555_6666, 4'hc, 0, 0);
		wait_all_responses();

		// Random traffic under stall and bready noise
		stall_rand = 1'b1;
		bready_rand = 1'b1;
		for (i = 0; i < 40; i++)
		begin
			stim_seed = lcg_step(stim_seed);
			s1 = stim_seed;
			stim_seed = lcg_step(stim_seed);
			s2 = stim_seed;
			send_write(axi_addr_t'(s1 >> 5) & 28'h7ff_ffff, {s1[23:8], s2[23:8]},
				s2[11:8], (s1 >> 28) % 3, s2[27:26]);
		end
		wait_all_responses();

		// Fill the queue with bready held low
		stall_rand = 1'b0;
		bready_rand = 1'b0;
		bready_hold = 40;
		for (i = 0; i < FIFO_DEPTH + 1; i++)
			send_write(28'h010_0000 + axi_addr_t'(i * 4), 32'hab00_0000 + i, 4'hf, 0, 0);
		// Eight writes in flight and the ninth held, both channels stalled
		if (o_axi_awready)
			report_mismatch("o_axi_awready", o_axi_awready, 0);
		else if (o_axi_wready)
			report_mismatch("o_axi_wready", o_axi_wready, 0);
		send_write(28'h010_0100, 32'hcafe_0001, 4'h5, 0, 0);
		wait_all_responses();

		// Lone error write, then normal ones
		send_write(28'h800_0010, 32'hdead_beef, 4'hf, 0, 0);
		wait_all_responses();
		for (i = 0; i < 3; i++)
			send_write(28'h000_0104 + axi_addr_t'(i * 8), 32'h0bad_0000 + i, 4'ha, i % 3, 1);
		wait_all_responses();

		if (b_count != sent_count)
			report_mismatch("b_count", b_count, sent_count);
		else if (log_count != sent_count)
			report_mismatch("log_count", log_count, sent_count);
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* project.f */
logic/axil_wb_pkg.sv
logic/axil_write_join.sv
logic/wb_write_master.sv
logic/write_resp_tracker.sv
logic/axil_wb_write_bridge.sv
sim/wb_slave_model.sv
sim/tb_axil_wb_write_bridge.sv
